//--- rk11.f
+incdir+.
rk11_pkg.sv
rk11_regs.sv
ide_pio.sv
rk11_dma.sv
rk11_ctrl.sv
rk11.sv
rk11_sva.sv
rk11_tb.sv

//--- Bender.yml
package:
  name: rk11

sources:
  - include_dirs:
      - .
    files:
      - rk11_pkg.sv
      - rk11_regs.sv
      - ide_pio.sv
      - rk11_dma.sv
      - rk11_ctrl.sv
      - rk11.sv
  - target: test
    include_dirs:
      - .
    files:
      - rk11_sva.sv
      - rk11_tb.sv

//--- rk11_tb.sv
// testbench for the rk11 top, runs a table of disk commands against IDE disk and memory models
`timescale 1ns/10ps
`default_nettype none
`include "rk11_defs.svh"

module rk11_tb import rk11_pkg::*;
();

   localparam int NROWS = 8;

   logic        clk = 1'b0;
   logic        reset;
   logic [12:0] iopage_addr;
   logic [15:0] data_in;
   logic        iopage_wr;
   logic        iopage_rd;
   logic [15:0] data_out;
   logic        decode;
   logic        interrupt;
   logic [7:0]  vector;
   logic        dma_req;
   logic        dma_ack;
   logic [17:0] dma_addr;
   logic [15:0] dma_data_in;
   logic [15:0] dma_data_out;
   logic        dma_rd;
   logic        dma_wr;
   wire  [15:0] ide_data_bus;
   logic        ide_dior;
   logic        ide_diow;
   logic [1:0]  ide_cs;
   logic [2:0]  ide_da;

   // stimulus table
   logic [2:0]  row_func [NROWS];
   logic [15:0] row_da [NROWS];
   int          row_n [NROWS];
   logic [15:0] row_ba [NROWS];
   logic        row_ie [NROWS];
   logic        row_err [NROWS];

   logic [15:0] mem [0:8191];
   logic [15:0] disk_mem [0:4095];
   logic [7:0]  tf_devctrl;
   logic [7:0]  tf_seccnt;
   logic [7:0]  tf_secnum;
   logic [7:0]  tf_cyllow;
   logic [7:0]  tf_cylhigh;
   logic [7:0]  tf_drvhead;
   logic [7:0]  tf_command;
   logic [27:0] disk_lba;
   logic [7:0]  disk_ptr;
   int          sec_left;
   logic        disk_drq;
   logic        disk_err;
   logic        inject_err;
   int          drq_phases;
   logic [4:0]  ide_sel;
   logic [15:0] status_word;
   logic [15:0] disk_rdata;
   logic [4:0]  wr_sel;
   logic [4:0]  rd_sel;
   logic [15:0] wr_val;
   logic        diow_q;
   logic        dior_q;
   int          ack_wait;
   int          int_cycles;
   int          errors;
   int          tests_run;
   int          tests_bad;
   int          cycles;
   int          cycle_limit = 32'h7fff_ffff;

   rk11 i_dut (.*);

   always #10 clk = ~clk;

   // timeout guard
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: commands did not complete within %0d clock cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (act !== exp)
      begin
         errors = errors + 1;
         $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   // memory model, ack after 0 to 3 idle cycles
   assign dma_data_out = mem[dma_addr[13:1]];

   always @(posedge clk)
   begin
      #2;
      if (dma_ack)
         dma_ack = 1'b0;
      else if (dma_req === 1'b1)
      begin
         if (ack_wait == 0)
         begin
            dma_ack  = 1'b1;
            ack_wait = $urandom % 4;
         end
         else
            ack_wait = ack_wait - 1;
      end
   end

   always @(negedge clk)
   begin
      if (dma_wr === 1'b1)
         mem[dma_addr[13:1]] = dma_data_in;
   end

   // IDE disk model, BSY always clear
   assign ide_sel      = {ide_cs, ide_da};
   assign status_word  = {8'd0, 1'b0, 1'b1, 2'b00, disk_drq, 2'b00, disk_err};
   assign ide_data_bus = (ide_dior === 1'b0) ? disk_rdata : 16'hzzzz;

   always_comb
   begin
      case (ide_sel)
         ata_data:
            disk_rdata = disk_mem[{disk_lba[3:0], disk_ptr}];
         ata_status_cmd, ata_alt_devctrl:
            disk_rdata = status_word;
         default:
            disk_rdata = 16'h0000;
      endcase
   end

   task automatic step_pointer;
      if (disk_ptr == 8'hff)
      begin
         disk_ptr = 8'd0;
         disk_lba = disk_lba + 28'd1;
         sec_left = sec_left - 1;
         if (sec_left > 0)
            drq_phases = drq_phases + 1;
         else
            disk_drq = 1'b0;
      end
      else
         disk_ptr = disk_ptr + 8'd1;
   endtask

   task automatic store_taskfile(input logic [4:0] sel, input logic [15:0] val);
      case (sel)
         ata_alt_devctrl: tf_devctrl = val[7:0];
         ata_seccnt:      tf_seccnt  = val[7:0];
         ata_secnum:      tf_secnum  = val[7:0];
         ata_cyllow:      tf_cyllow  = val[7:0];
         ata_cylhigh:     tf_cylhigh = val[7:0];
         ata_drvhead:     tf_drvhead = val[7:0];
         ata_data:
         begin
            disk_mem[{disk_lba[3:0], disk_ptr}] = val;
            step_pointer();
         end
         ata_status_cmd:
         begin
            if (val == `ATA_CMD_READ || val == `ATA_CMD_WRITE)
            begin
               tf_command = val[7:0];
               disk_lba = {tf_drvhead[3:0], tf_cylhigh, tf_cyllow, tf_secnum};
               disk_ptr = 8'd0;
               sec_left = (tf_seccnt == 8'd0) ? 256 : int'(tf_seccnt);
               disk_err = inject_err;
               disk_drq = !inject_err;
               if (!inject_err)
                  drq_phases = drq_phases + 1;
            end
         end
         default:
            ;
      endcase
   endtask

   // bus sampled mid-cycle, access completes when the strobe goes high
   always @(negedge clk)
   begin
      if (ide_diow === 1'b0)
      begin
         wr_sel = ide_sel;
         wr_val = ide_data_bus;
      end
      if (ide_dior === 1'b0)
         rd_sel = ide_sel;
      if (ide_diow === 1'b1 && diow_q === 1'b0)
         store_taskfile(wr_sel, wr_val);
      if (ide_dior === 1'b1 && dior_q === 1'b0 && rd_sel == ata_data)
         step_pointer();
      diow_q = ide_diow;
      dior_q = ide_dior;
   end

   // interrupt length and vector
   always @(negedge clk)
   begin
      if (reset === 1'b0)
      begin
         if (interrupt)
            int_cycles = int_cycles + 1;
         compare_value("vector", interrupt ? 8'o220 : 8'd0, vector);
      end
   end

   task automatic write_reg(input logic [12:0] addr, input logic [15:0] val);
      @(posedge clk);
      #2;
      iopage_addr = addr;
      data_in     = val;
      iopage_wr   = 1'b1;
      @(posedge clk);
      #2;
      iopage_wr = 1'b0;
   endtask

   task automatic read_reg(input logic [12:0] addr, output logic [15:0] val);
      @(posedge clk);
      #2;
      iopage_addr = addr;
      iopage_rd   = 1'b1;
      @(negedge clk);
      val = data_out;
      @(posedge clk);
      #2;
      iopage_rd = 1'b0;
   endtask

   task automatic check_decode(input logic [12:0] addr, input logic exp);
      @(posedge clk);
      #2;
      iopage_addr = addr;
      @(negedge clk);
      compare_value("decode", exp, decode);
   endtask

   task automatic wait_done;
      logic [15:0] cs;
      cs = 16'd0;
      while (!(cs[7] && !cs[0]))
         read_reg(`RK_ADDR_RKCS, cs);
   endtask

   task automatic check_registers;
      logic [15:0] val;
      int          err_before;
      err_before = errors;
      int_cycles = 0;
      write_reg(`RK_ADDR_RKWC, 16'o123456);
      write_reg(`RK_ADDR_RKBA, 16'h5a5a);
      write_reg(`RK_ADDR_RKDA, 16'h1234);
      // done, ie, mex and function set, go clear
      write_reg(`RK_ADDR_RKCS, 16'h00f6);
      read_reg(`RK_ADDR_RKWC, val);
      compare_value("rkwc", 16'o123456, val);
      read_reg(`RK_ADDR_RKBA, val);
      compare_value("rkba", 16'h5a5a, val);
      read_reg(`RK_ADDR_RKDA, val);
      compare_value("rkda", 16'h1234, val);
      read_reg(`RK_ADDR_RKCS, val);
      compare_value("rkcs", 16'h00f6, val);
      read_reg(`RK_ADDR_RKDS, val);
      compare_value("rkds", 16'h0000, val);
      read_reg(`RK_ADDR_RKER, val);
      compare_value("rker", 16'h0000, val);
      write_reg(`RK_ADDR_RKCS, 16'h0000);
      read_reg(`RK_ADDR_RKCS, val);
      compare_value("rkcs", 16'h0000, val);
      for (int a = 13'o17400; a <= 13'o17412; a = a + 2)
         check_decode(13'(a), 1'b1);
      check_decode(13'o17376, 1'b0);
      check_decode(13'o17414, 1'b0);
      check_decode(13'o00000, 1'b0);
      compare_value("interrupt cycles", 0, int_cycles);
      tests_run = tests_run + 1;
      if (errors != err_before)
         tests_bad = tests_bad + 1;
      $display("test reg (register access): %s", (errors == err_before) ? "ok" : "mismatch");
   endtask

   function automatic string func_name(input logic [2:0] f);
      if (f == fn_read)
         return "read";
      else if (f == fn_write)
         return "write";
      return "other";
   endfunction

   task automatic run_row(input int r);
      logic [15:0] exp_words [512];
      logic [15:0] val;
      int          err_before;
      int          n;
      int          base_w;
      int          base_d;
      logic        is_rd;
      logic        data_row;
      err_before = errors;
      n          = row_n[r];
      base_w     = int'(row_ba[r]) / 2;
      base_d     = int'(row_da[r]) * 256;
      is_rd      = (row_func[r] == fn_read);
      data_row   = (row_func[r] == fn_read || row_func[r] == fn_write) && !row_err[r];
      for (int k = 0; k < n; k++)
         exp_words[k] = is_rd ? disk_mem[base_d + k] : mem[base_w + k];
      // drive drops a partial sector between commands
      disk_drq   = 1'b0;
      inject_err = row_err[r];
      drq_phases = 0;
      int_cycles = 0;
      write_reg(`RK_ADDR_RKWC, 16'(-n));
      write_reg(`RK_ADDR_RKBA, row_ba[r]);
      write_reg(`RK_ADDR_RKDA, row_da[r]);
      write_reg(`RK_ADDR_RKCS, {8'd0, 1'b0, row_ie[r], 2'b00, row_func[r], 1'b1});
      wait_done();
      repeat (4) @(posedge clk);
      read_reg(`RK_ADDR_RKCS, val);
      compare_value("rkcs.err", row_err[r], val[15]);
      compare_value("rkcs.done", 1, val[7]);
      compare_value("rkcs.go", 0, val[0]);
      read_reg(`RK_ADDR_RKWC, val);
      compare_value("rkwc", data_row ? 16'd0 : 16'(-n), val);
      read_reg(`RK_ADDR_RKBA, val);
      compare_value("rkba", data_row ? 16'(row_ba[r] + 2 * n) : row_ba[r], val);
      if (data_row)
      begin
         compare_value("seccnt", (n + 255) / 256, tf_seccnt);
         // nIEN set, LBA mode, opcode matching the function
         compare_value("devctrl", 8'h02, tf_devctrl);
         compare_value("drvhead.lba", 1'b1, tf_drvhead[6]);
         compare_value("command", is_rd ? 8'h20 : 8'h30, tf_command);
         for (int k = 0; k < n; k++)
         begin
            if (is_rd)
               compare_value("mem", exp_words[k], mem[base_w + k]);
            else
               compare_value("disk", exp_words[k], disk_mem[base_d + k]);
         end
      end
      compare_value("drq phases", data_row ? (n + 255) / 256 : 0, drq_phases);
      compare_value("interrupt cycles", row_ie[r] ? 2 : 0, int_cycles);
      tests_run = tests_run + 1;
      if (errors != err_before)
         tests_bad = tests_bad + 1;
      $display("test %0d (%s, %0d words, ie %0d, err %0d): %s", r, func_name(row_func[r]), n,
               row_ie[r], row_err[r], (errors == err_before) ? "ok" : "mismatch");
   endtask

   task automatic load_table;
      // func, rkda, words, rkba, ie, expect error
      row_func = '{fn_read, fn_write, fn_read, fn_write, fn_read, 3'b111, fn_write, fn_read};
      row_da   = '{16'd2, 16'd5, 16'd8, 16'd3, 16'd1, 16'd0, 16'd12, 16'd5};
      row_n    = '{10, 20, 512, 300, 4, 8, 256, 20};
      row_ba   = '{16'h0100, 16'h0400, 16'h1000, 16'h2000, 16'h0800, 16'h0600, 16'h3000,
                   16'h3400};
      row_ie   = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
      // row 4 fails on the disk, row 5 then clears the error bit
      row_err  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
   endtask

   initial
   begin
      ack_wait    = $urandom(32'hfa3c);
      ack_wait    = 0;
      reset       = 1'b1;
      iopage_addr = 13'd0;
      data_in     = 16'd0;
      iopage_wr   = 1'b0;
      iopage_rd   = 1'b0;
      dma_ack     = 1'b0;
      diow_q      = 1'b1;
      dior_q      = 1'b1;
      disk_drq    = 1'b0;
      disk_err    = 1'b0;
      inject_err  = 1'b0;
      disk_lba    = 28'd0;
      disk_ptr    = 8'd0;
      tf_command  = 8'd0;
      sec_left    = 0;
      drq_phases  = 0;
      int_cycles  = 0;
      errors      = 0;
      tests_run   = 0;
      tests_bad   = 0;
      cycles      = 0;
      load_table();
      cycle_limit = 2000;
      for (int r = 0; r < NROWS; r++)
         cycle_limit = cycle_limit + row_n[r] * 40;
      for (int k = 0; k < 8192; k++)
         mem[k] = 16'($urandom) ^ 16'(k);
      for (int k = 0; k < 4096; k++)
         disk_mem[k] = 16'($urandom) ^ 16'(k * 7);
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;
      check_registers();
      for (int r = 0; r < NROWS; r++)
         run_row(r);
      $display("%0d tests run, %0d with mismatches, %0d check errors", tests_run, tests_bad,
               errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- rk11_sva.sv
// assertions on the rk11 DMA and ATA request rules, bound into the rk11 top
`timescale 1ns/10ps
`default_nettype none

module rk11_sva
(
   input logic clk,
   input logic reset,
   input logic dma_req,
   input logic dma_ack,
   input logic dma_rd,
   input logic dma_wr,
   input logic ata_rd,
   input logic ata_wr,
   input logic interrupt
);

   // memory strobes only in the ack cycle
   a_strobe_with_ack: assert property (@(posedge clk) disable iff (reset)
      (dma_rd || dma_wr) |-> dma_ack)
      else $error("dma strobe without dma_ack");

   a_ata_one_request: assert property (@(posedge clk) disable iff (reset)
      !(ata_rd && ata_wr))
      else $error("ata_rd and ata_wr both high");

   // interrupt pulse is two cycles long
   a_int_two_cycles: assert property (@(posedge clk) disable iff (reset)
      $rose(interrupt) |=> interrupt ##1 !interrupt)
      else $error("interrupt pulse not two cycles long");

   // request level held until acked
   a_req_held: assert property (@(posedge clk) disable iff (reset)
      (dma_req && !dma_ack) |=> dma_req)
      else $error("dma_req dropped before dma_ack");

endmodule

// FSM and DMA port signals as they meet in the top
bind rk11 rk11_sva i_sva (
   .clk(clk),
   .reset(reset),
   .dma_req(dma_req),
   .dma_ack(dma_ack),
   .dma_rd(dma_rd),
   .dma_wr(dma_wr),
   .ata_rd(ata_rd),
   .ata_wr(ata_wr),
   .interrupt(interrupt)
);

`default_nettype wire

//--- rk11.sv
// RK11 disk controller top, joins the CPU register port, the DMA port and the ATA PIO port
`timescale 1ns/10ps
`default_nettype none

module rk11 import rk11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [12:0] iopage_addr,
   input  logic [15:0] data_in,
   input  logic        iopage_wr,
   input  logic        iopage_rd,
   output logic [15:0] data_out,
   output logic        decode,
   output logic        interrupt,
   output logic [7:0]  vector,
   output logic        dma_req,
   input  logic        dma_ack,
   output logic [17:0] dma_addr,
   output logic [15:0] dma_data_in,
   input  logic [15:0] dma_data_out,
   output logic        dma_rd,
   output logic        dma_wr,
   inout  wire  [15:0] ide_data_bus,
   output logic        ide_dior,
   output logic        ide_diow,
   output logic [1:0]  ide_cs,
   output logic [2:0]  ide_da
);

   logic        go;
   rk_func_t    func;
   logic        ie;
   logic [15:0] rkwc;
   logic [15:0] rkda;
   logic [17:0] bus_addr;
   logic        wc_zero;
   logic        wc_sector_end;
   logic        inc_wc;
   logic        inc_ba;
   logic        set_err;
   logic        set_done;
   logic        clear_go;
   logic        ata_rd;
   logic        ata_wr;
   ata_reg_t    ata_addr;
   logic [15:0] ata_in;
   logic [15:0] ata_out;
   logic        ata_done;
   logic        load_ata;
   logic        mem_wr_req;
   logic        mem_rd_req;
   logic        mem_done;
   logic [15:0] word;
   logic [15:0] reg_data;

   // read data only while the CPU reads
   assign data_out = iopage_rd ? reg_data : 16'd0;

   rk11_regs i_regs (.*, .data_out(reg_data), .busy_n());

   rk11_ctrl i_ctrl (.*);

   rk11_dma i_dma (.*);

   ide_pio i_ide (.*);

endmodule

`default_nettype wire

//--- rk11_ctrl.sv
// RK11 command FSM, sets up the ATA task file, polls status and moves each data word
`timescale 1ns/10ps
`default_nettype none
`include "rk11_defs.svh"

module rk11_ctrl import rk11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        go,
   input  rk_func_t    func,
   input  logic        ie,
   input  logic [15:0] rkwc,
   input  logic [15:0] rkda,
   input  logic        wc_zero,
   input  logic        wc_sector_end,
   input  logic [15:0] ata_out,
   input  logic        ata_done,
   input  logic [15:0] word,
   input  logic        mem_done,
   output logic        ata_rd,
   output logic        ata_wr,
   output ata_reg_t    ata_addr,
   output logic [15:0] ata_in,
   output logic        load_ata,
   output logic        mem_wr_req,
   output logic        mem_rd_req,
   output logic        inc_wc,
   output logic        inc_ba,
   output logic        set_err,
   output logic        set_done,
   output logic        clear_go,
   output logic        interrupt,
   output logic [7:0]  vector
);

   rk_state_t state;
   rk_state_t next;
   rk_state_t word_next;
   logic      int_q;
   logic      is_read;
   logic      not_busy;

   assign is_read  = (func == fn_read);
   assign not_busy = !ata_out[`ATA_ST_BSY];

   // after a word: end of transfer, next sector, or next word
   always_comb
   begin
      if (wc_zero)
         word_next = fin_alt;
      else if (wc_sector_end)
         word_next = poll_alt;
      else if (is_read)
         word_next = rd_data;
      else
         word_next = wr_mem;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= idle;
         int_q <= 1'b0;
      end
      else
      begin
         state <= next;
         int_q <= ie && (state == finish || state == int_hold);
      end
   end

   // two cycles, both after done is set
   assign interrupt = int_q && ie;
   assign vector    = interrupt ? `RK_VECTOR : 8'd0;

   always_comb
   begin
      next       = state;
      ata_rd     = 1'b0;
      ata_wr     = 1'b0;
      ata_addr   = ata_status_cmd;
      ata_in     = 16'd0;
      load_ata   = 1'b0;
      mem_wr_req = 1'b0;
      mem_rd_req = 1'b0;
      inc_wc     = 1'b0;
      inc_ba     = 1'b0;
      set_err    = 1'b0;
      set_done   = 1'b0;
      clear_go   = 1'b0;
      case (state)
         idle:
         begin
            if (go && (func == fn_read || func == fn_write))
               next = poll_ready;
            else if (go)
               next = finish;
         end
         poll_ready:
         begin
            ata_rd = 1'b1;
            if (ata_done && not_busy && !ata_out[`ATA_ST_DRQ])
               next = set_devctrl;
         end
         set_devctrl, set_seccnt, set_lba0, set_lba1, set_lba2, set_drvhead, set_command:
         begin
            ata_wr = 1'b1;
            if (ata_done)
               next = rk_state_t'(state + 5'd1);
            case (state)
               set_devctrl:
               begin
                  // nIEN, status is polled
                  ata_addr = ata_alt_devctrl;
                  ata_in   = 16'h0002;
               end
               set_seccnt:
               begin
                  // sectors covered by the negative word count
                  ata_addr = ata_seccnt;
                  ata_in   = {8'd0, ~rkwc[15:8] + 8'd1};
               end
               set_lba0:
               begin
                  ata_addr = ata_secnum;
                  ata_in   = {8'd0, rkda[7:0]};
               end
               set_lba1:
               begin
                  ata_addr = ata_cyllow;
                  ata_in   = {8'd0, rkda[15:8]};
               end
               set_lba2:
                  ata_addr = ata_cylhigh;
               set_drvhead:
               begin
                  // LBA mode, drive 0
                  ata_addr = ata_drvhead;
                  ata_in   = 16'h0040;
               end
               default:
                  ata_in = is_read ? `ATA_CMD_READ : `ATA_CMD_WRITE;
            endcase
         end
         poll_alt, fin_alt:
         begin
            ata_rd   = 1'b1;
            ata_addr = ata_alt_devctrl;
            if (ata_done)
               next = (state == poll_alt) ? poll_drq : fin_status;
         end
         poll_drq:
         begin
            ata_rd = 1'b1;
            if (ata_done && not_busy && ata_out[`ATA_ST_ERR])
            begin
               set_err = 1'b1;
               next    = finish;
            end
            else if (ata_done && not_busy && ata_out[`ATA_ST_DRQ])
               next = is_read ? rd_data : wr_mem;
         end
         rd_data:
         begin
            ata_rd   = 1'b1;
            ata_addr = ata_data;
            if (ata_done)
            begin
               load_ata = 1'b1;
               inc_wc   = 1'b1;
               next     = rd_mem;
            end
         end
         rd_mem:
         begin
            mem_wr_req = 1'b1;
            if (mem_done)
            begin
               inc_ba = 1'b1;
               next   = word_next;
            end
         end
         wr_mem:
         begin
            mem_rd_req = 1'b1;
            if (mem_done)
            begin
               inc_wc = 1'b1;
               inc_ba = 1'b1;
               next   = wr_data;
            end
         end
         wr_data:
         begin
            ata_wr   = 1'b1;
            ata_addr = ata_data;
            ata_in   = word;
            if (ata_done)
               next = word_next;
         end
         fin_status:
         begin
            // wait out the flush of the last sector
            ata_rd = 1'b1;
            if (ata_done && not_busy)
            begin
               set_err = ata_out[`ATA_ST_ERR];
               next    = finish;
            end
         end
         finish:
         begin
            set_done = 1'b1;
            clear_go = 1'b1;
            next     = ie ? int_hold : idle;
         end
         default:
            next = idle;
      endcase
   end

endmodule

`default_nettype wire

//--- rk11_dma.sv
// DMA port of the rk11, moves one latched word between the ATA side and memory
`timescale 1ns/10ps
`default_nettype none

module rk11_dma
(
   input  logic        clk,
   input  logic        reset,
   input  logic [17:0] bus_addr,
   input  logic        load_ata,
   input  logic [15:0] ata_out,
   input  logic        mem_wr_req,
   input  logic        mem_rd_req,
   input  logic        dma_ack,
   input  logic [15:0] dma_data_out,
   output logic [15:0] word,
   output logic        mem_done,
   output logic        dma_req,
   output logic [17:0] dma_addr,
   output logic [15:0] dma_data_in,
   output logic        dma_rd,
   output logic        dma_wr
);

   logic ack_cycle;

   assign ack_cycle = dma_req && dma_ack;

   // held from the request level until the ack
   always_ff @(posedge clk)
   begin
      if (reset)
         dma_req <= 1'b0;
      else if (ack_cycle)
         dma_req <= 1'b0;
      else if (mem_wr_req || mem_rd_req)
         dma_req <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (load_ata)
         word <= ata_out;
      else if (dma_rd)
         word <= dma_data_out;
   end

   assign mem_done    = ack_cycle;
   assign dma_wr      = ack_cycle && mem_wr_req;
   assign dma_rd      = ack_cycle && mem_rd_req;
   assign dma_addr    = bus_addr;
   assign dma_data_in = word;

endmodule

`default_nettype wire

//--- ide_pio.sv
// ATA PIO bus-cycle engine, run by the rk11 FSM for each task-file or data access
`timescale 1ns/10ps
`default_nettype none
`include "rk11_defs.svh"

module ide_pio import rk11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        ata_rd,
   input  logic        ata_wr,
   input  ata_reg_t    ata_addr,
   input  logic [15:0] ata_in,
   output logic [15:0] ata_out,
   output logic        ata_done,
   inout  wire  [15:0] ide_data_bus,
   output logic        ide_dior,
   output logic        ide_diow,
   output logic [1:0]  ide_cs,
   output logic [2:0]  ide_da
);

   logic       active;
   logic       is_wr;
   logic       drive;
   logic [3:0] cnt;
   logic       last_strobe;

   assign last_strobe  = active && (cnt == 4'(`IDE_SETUP_CYC + `IDE_STROBE_CYC - 1));
   assign ide_data_bus = drive ? ata_in : 16'hzzzz;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         active   <= 1'b0;
         is_wr    <= 1'b0;
         drive    <= 1'b0;
         cnt      <= 4'd0;
         ata_done <= 1'b0;
         ide_dior <= 1'b1;
         ide_diow <= 1'b1;
         ide_cs   <= 2'd0;
         ide_da   <= 3'd0;
      end
      else
      begin
         ata_done <= 1'b0;
         if (!active)
         begin
            // write data held one clock past the strobe
            drive <= 1'b0;
            // request level is still up during the done cycle
            if ((ata_rd || ata_wr) && !ata_done)
            begin
               active           <= 1'b1;
               is_wr            <= ata_wr;
               drive            <= ata_wr;
               cnt              <= 4'd0;
               {ide_cs, ide_da} <= ata_addr;
            end
         end
         else
         begin
            cnt <= cnt + 4'd1;
            if (cnt == 4'(`IDE_SETUP_CYC - 1))
            begin
               ide_dior <= is_wr;
               ide_diow <= !is_wr;
            end
            if (last_strobe)
            begin
               ide_dior <= 1'b1;
               ide_diow <= 1'b1;
               active   <= 1'b0;
               ata_done <= 1'b1;
            end
         end
      end
   end

   // read data taken on the last strobe clock
   always_ff @(posedge clk)
   begin
      if (last_strobe && !is_wr)
         ata_out <= ide_data_bus;
   end

endmodule

`default_nettype wire

//--- rk11_regs.sv
// RK11 register file, used by the rk11 top for CPU access and the transfer counters
`timescale 1ns/10ps
`default_nettype none
`include "rk11_defs.svh"

module rk11_regs import rk11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [12:0] iopage_addr,
   input  logic [15:0] data_in,
   input  logic        iopage_wr,
   input  logic        inc_wc,
   input  logic        inc_ba,
   input  logic        set_err,
   input  logic        set_done,
   input  logic        clear_go,
   output logic [15:0] data_out,
   output logic        decode,
   output logic        go,
   output rk_func_t    func,
   output logic        ie,
   output logic        busy_n,
   output logic [15:0] rkwc,
   output logic [15:0] rkda,
   output logic [17:0] bus_addr,
   output logic        wc_zero,
   output logic        wc_sector_end
);

   logic        cs_err;
   logic        cs_done;
   logic [1:0]  cs_mex;
   logic [2:0]  cs_func;
   logic [15:0] rkba;
   logic        wr_cs;
   logic        wr_wc;
   logic        wr_ba;
   logic        wr_da;

   assign wr_cs = iopage_wr && (iopage_addr == `RK_ADDR_RKCS);
   assign wr_wc = iopage_wr && (iopage_addr == `RK_ADDR_RKWC);
   assign wr_ba = iopage_wr && (iopage_addr == `RK_ADDR_RKBA);
   assign wr_da = iopage_wr && (iopage_addr == `RK_ADDR_RKDA);

   always_comb
   begin
      decode   = 1'b1;
      data_out = 16'd0;
      case (iopage_addr)
         // drive status and error detail read as zero
         `RK_ADDR_RKDS, `RK_ADDR_RKER:
            data_out = 16'd0;
         `RK_ADDR_RKCS:
            data_out = {cs_err, 7'd0, cs_done, ie, cs_mex, cs_func, go};
         `RK_ADDR_RKWC:
            data_out = rkwc;
         `RK_ADDR_RKBA:
            data_out = rkba;
         `RK_ADDR_RKDA:
            data_out = rkda;
         default:
            decode = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cs_err  <= 1'b0;
         cs_done <= 1'b0;
         ie      <= 1'b0;
         cs_mex  <= 2'd0;
         cs_func <= 3'd0;
         go      <= 1'b0;
         rkwc    <= 16'd0;
         rkba    <= 16'd0;
         rkda    <= 16'd0;
      end
      else
      begin
         if (wr_cs)
         begin
            ie <= data_in[6];
            // only ie may change while a command runs
            if (busy_n)
            begin
               cs_done <= data_in[7];
               cs_mex  <= data_in[5:4];
               cs_func <= data_in[3:1];
               go      <= data_in[0];
               if (data_in[0])
               begin
                  cs_done <= 1'b0;
                  cs_err  <= 1'b0;
               end
            end
         end
         if (wr_wc)
            rkwc <= data_in;
         if (wr_ba)
            rkba <= data_in;
         if (wr_da)
            rkda <= data_in;

         // FSM updates
         if (inc_wc)
            rkwc <= rkwc + 16'd1;
         if (inc_ba)
            {cs_mex, rkba} <= bus_addr + 18'd2;
         if (set_err)
            cs_err <= 1'b1;
         if (set_done)
            cs_done <= 1'b1;
         if (clear_go)
            go <= 1'b0;
      end
   end

   assign func     = rk_func_t'(cs_func);
   assign busy_n   = ~go;
   assign bus_addr = {cs_mex, rkba};

   // word count runs up from a negative value
   assign wc_zero       = (rkwc == 16'd0);
   assign wc_sector_end = (rkwc[$clog2(`RK_SECTOR_WORDS)-1:0] == '0);

endmodule

`default_nettype wire

//--- rk11_pkg.sv
// enum types shared by the rk11 modules, taken in by a wildcard import in each module header
`default_nettype none

package rk11_pkg;

   // command FSM, the set_* states must stay in task-file order
   typedef enum logic [4:0] {
      idle,
      poll_ready,
      set_devctrl,
      set_seccnt,
      set_lba0,
      set_lba1,
      set_lba2,
      set_drvhead,
      set_command,
      poll_alt,
      poll_drq,
      rd_data,
      rd_mem,
      wr_mem,
      wr_data,
      fin_alt,
      fin_status,
      finish,
      int_hold
   } rk_state_t;

   // RKCS bits 3:1
   typedef enum logic [2:0] {
      fn_other = 3'b000,
      fn_write = 3'b001,
      fn_read  = 3'b010
   } rk_func_t;

   // {cs, da} of the ATA register file
   typedef enum logic [4:0] {
      ata_alt_devctrl = 5'b01110,
      ata_data        = 5'b10000,
      ata_seccnt      = 5'b10010,
      ata_secnum      = 5'b10011,
      ata_cyllow      = 5'b10100,
      ata_cylhigh     = 5'b10101,
      ata_drvhead     = 5'b10110,
      ata_status_cmd  = 5'b10111
   } ata_reg_t;

endpackage

`default_nettype wire

//--- rk11_defs.svh
// rk11 constants for I/O page offsets, ATA codes and PIO timing, included by the RTL that needs them
`ifndef RK11_DEFS_SVH
`define RK11_DEFS_SVH

// register offsets on the I/O page
`define RK_ADDR_RKDS 13'o17400
`define RK_ADDR_RKER 13'o17402
`define RK_ADDR_RKCS 13'o17404
`define RK_ADDR_RKWC 13'o17406
`define RK_ADDR_RKBA 13'o17410
`define RK_ADDR_RKDA 13'o17412

// ATA status bits
`define ATA_ST_BSY 7
`define ATA_ST_DRQ 3
`define ATA_ST_ERR 0

// ATA commands
`define ATA_CMD_READ  16'h0020
`define ATA_CMD_WRITE 16'h0030

`define RK_VECTOR 8'o220

// PIO cycle, in clocks
`define IDE_SETUP_CYC  2
`define IDE_STROBE_CYC 4

`define RK_SECTOR_WORDS 256

`endif
